//--- source/core_pkg.sv
// Widths, typedefs and encodings shared by the RV32I subset core
// Only the major opcodes in opcode_e are executed, any other opcode halts the core
// Loads and stores are aligned, no misaligned splitting exists

package core_pkg;

  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NUM_REGS   = 32;

  // funct3 codes of the kept instructions
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;
  localparam logic [2:0] F3_LW      = 3'b010;
  localparam logic [2:0] F3_LBU     = 3'b100;
  localparam logic [2:0] F3_SW      = 3'b010;
  localparam logic [2:0] F3_SB      = 3'b000;

  // funct7 codes for register-register ops
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [3:0]            byte_en_t;

  // Major opcodes, instruction bits [6:0]
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_LOAD,
    WB_LINK
  } wb_sel_e;

  typedef enum logic [1:0] {
    ST_FETCH,
    ST_EXEC,
    ST_MEM,
    ST_HALT
  } ctrl_state_e;

endpackage

//--- source/core_ifs.sv
// Internal bundles from the decoder to its consumers
// All fields are combinational and meaningful only in EXEC and MEM
// issue_if.we doubles as the retire strobe, rd is zero when nothing is written

`timescale 1ns/1ps

interface issue_if
  import core_pkg::*;
();
  alu_op_e   alu_op;
  word_t     operand_a;
  word_t     operand_b;
  logic      branch_en;
  logic      branch_ne;
  logic      jump;
  word_t     branch_off;
  word_t     pc;
  logic      mem_req;
  logic      mem_we;
  logic      mem_byte;
  word_t     store_data;
  reg_addr_t rd;
  logic      we;
  wb_sel_e   wb_sel;

  modport decode (
    output alu_op, operand_a, operand_b, branch_en, branch_ne, jump, branch_off, pc,
           mem_req, mem_we, mem_byte, store_data, rd, we, wb_sel
  );
  modport execute (
    input alu_op, operand_a, operand_b, branch_en, branch_ne, jump, branch_off, pc, we
  );
  modport memory (input mem_req, mem_we, mem_byte, store_data);
  modport result (input rd, we, wb_sel, pc);
endinterface

interface rf_read_if
  import core_pkg::*;
();
  reg_addr_t rs1;
  reg_addr_t rs2;
  word_t     rdata_a;
  word_t     rdata_b;

  modport request (output rs1, rs2, input rdata_a, rdata_b);
  modport file (input rs1, rs2, output rdata_a, rdata_b);
endinterface

//--- source/fetch_unit.sv
// Program counter and instruction port sequencing
// One fetch in flight at a time, boot_addr_i must be static during and after reset
// The pc changes only on pc_load_i, which comes at the end of an instruction

`timescale 1ns/1ps

module fetch_unit
  import core_pkg::*;
(
  input  logic  clk,
  input  logic  rst_ni,
  input  word_t boot_addr_i,
  input  logic  fetch_start_i,
  input  word_t pc_next_i,
  input  logic  pc_load_i,
  output logic  instr_req_o,
  input  logic  instr_gnt_i,
  input  logic  instr_rvalid_i,
  output word_t instr_addr_o,
  input  word_t instr_rdata_i,
  output word_t pc_o,
  output word_t instr_o,
  output logic  instr_done_o
);

  word_t pc_q;
  word_t instr_q;
  logic  req_q;
  logic  wait_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q <= boot_addr_i;
    end else if (pc_load_i) begin
      pc_q <= pc_next_i;
    end
  end

  // Request held until granted, then wait for the single rvalid
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q  <= 1'b0;
      wait_q <= 1'b0;
    end else begin
      if (fetch_start_i) begin
        req_q <= 1'b1;
      end else if (instr_gnt_i) begin
        req_q <= 1'b0;
      end
      if (req_q && instr_gnt_i) begin
        wait_q <= 1'b1;
      end else if (instr_rvalid_i) begin
        wait_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (instr_done_o) begin
      instr_q <= instr_rdata_i;
    end
  end

  assign instr_req_o  = req_q;
  assign instr_addr_o = pc_q;
  assign instr_done_o = wait_q & instr_rvalid_i;
  assign pc_o         = pc_q;
  assign instr_o      = instr_q;

endmodule

//--- source/decode_unit.sv
// Instruction decoder and control FSM, one instruction in flight at a time
// Unsupported opcodes or funct fields send the FSM to HALT, which never exits
// EXEC lasts one cycle, MEM lasts until the load/store unit reports completion

`timescale 1ns/1ps

module decode_unit
  import core_pkg::*;
(
  input  logic       clk,
  input  logic       rst_ni,
  input  word_t      instr_i,
  input  word_t      pc_i,
  input  logic       instr_done_i,
  input  logic       mem_done_i,
  output logic       fetch_start_o,
  output logic       halted_o,
  issue_if.decode    issue,
  rf_read_if.request rf_rd
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        fetch_busy_q;

  opcode_e     opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  word_t       imm_i;
  word_t       imm_s;
  word_t       imm_b;
  word_t       imm_u;
  word_t       imm_j;

  alu_op_e     alu_op;
  wb_sel_e     wb_sel;
  word_t       imm;
  logic        use_imm;
  logic        rd_we;
  logic        is_mem;
  logic        mem_we;
  logic        mem_byte;
  logic        branch_en;
  logic        branch_ne;
  logic        jump;
  logic        illegal;

  ////////////////////////////////////////////////////////////////////////////
  // Fields and immediates
  ////////////////////////////////////////////////////////////////////////////

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  assign imm_i = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{(XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{(XLEN-12){instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{(XLEN-20){instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  ////////////////////////////////////////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    alu_op    = ALU_ADD;
    wb_sel    = WB_ALU;
    imm       = imm_i;
    use_imm   = 1'b0;
    rd_we     = 1'b0;
    is_mem    = 1'b0;
    mem_we    = 1'b0;
    mem_byte  = 1'b0;
    branch_en = 1'b0;
    branch_ne = 1'b0;
    jump      = 1'b0;
    illegal   = 1'b0;
    unique case (opcode)
      OPC_OP, OPC_OP_IMM: begin
        rd_we   = 1'b1;
        use_imm = (opcode == OPC_OP_IMM);
        unique case (funct3)
          F3_ADD_SUB: alu_op = (!use_imm && funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
          F3_SLT:     alu_op = ALU_SLT;
          F3_XOR:     alu_op = ALU_XOR;
          F3_OR:      alu_op = ALU_OR;
          F3_AND:     alu_op = ALU_AND;
          default:    illegal = 1'b1;
        endcase
        // Only SUB may carry a nonzero funct7
        if (!use_imm && funct7 != F7_BASE && !(funct3 == F3_ADD_SUB && funct7 == F7_SUB)) begin
          illegal = 1'b1;
        end
      end
      OPC_LUI: begin
        rd_we   = 1'b1;
        use_imm = 1'b1;
        imm     = imm_u;
        alu_op  = ALU_PASS_B;
      end
      OPC_BRANCH: begin
        branch_en = 1'b1;
        alu_op    = ALU_SUB;
        branch_ne = (funct3 == F3_BNE);
        illegal   = (funct3 != F3_BEQ) && (funct3 != F3_BNE);
      end
      OPC_JAL: begin
        jump   = 1'b1;
        rd_we  = 1'b1;
        wb_sel = WB_LINK;
      end
      OPC_LOAD: begin
        is_mem   = 1'b1;
        rd_we    = 1'b1;
        use_imm  = 1'b1;
        wb_sel   = WB_LOAD;
        mem_byte = (funct3 == F3_LBU);
        illegal  = (funct3 != F3_LW) && (funct3 != F3_LBU);
      end
      OPC_STORE: begin
        is_mem   = 1'b1;
        mem_we   = 1'b1;
        use_imm  = 1'b1;
        imm      = imm_s;
        mem_byte = (funct3 == F3_SB);
        illegal  = (funct3 != F3_SW) && (funct3 != F3_SB);
      end
      default: illegal = 1'b1;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_FETCH: begin
        if (instr_done_i) begin
          state_d = ST_EXEC;
        end
      end
      ST_EXEC: begin
        if (illegal) begin
          state_d = ST_HALT;
        end else if (is_mem) begin
          state_d = ST_MEM;
        end else begin
          state_d = ST_FETCH;
        end
      end
      ST_MEM: begin
        if (mem_done_i) begin
          state_d = ST_FETCH;
        end
      end
      default: state_d = ST_HALT;
    endcase
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= ST_FETCH;
      fetch_busy_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (fetch_start_o) begin
        fetch_busy_q <= 1'b1;
      end else if (instr_done_i) begin
        fetch_busy_q <= 1'b0;
      end
    end
  end

  // One start pulse per visit to FETCH
  assign fetch_start_o = (state_q == ST_FETCH) && !fetch_busy_q;
  assign halted_o      = (state_q == ST_HALT);

  assign rf_rd.rs1 = instr_i[19:15];
  assign rf_rd.rs2 = instr_i[24:20];

  assign issue.alu_op     = alu_op;
  assign issue.operand_a  = rf_rd.rdata_a;
  assign issue.operand_b  = use_imm ? imm : rf_rd.rdata_b;
  assign issue.branch_en  = branch_en;
  assign issue.branch_ne  = branch_ne;
  assign issue.jump       = jump;
  assign issue.branch_off = jump ? imm_j : imm_b;
  assign issue.pc         = pc_i;
  assign issue.mem_req    = is_mem && !illegal && (state_q == ST_EXEC);
  assign issue.mem_we     = mem_we;
  assign issue.mem_byte   = mem_byte;
  assign issue.store_data = rf_rd.rdata_b;
  assign issue.rd         = rd_we ? instr_i[11:7] : '0;
  assign issue.wb_sel     = wb_sel;

  // Retire at the end of EXEC, or on mem_done for loads and stores
  assign issue.we = ((state_q == ST_EXEC) && !is_mem && !illegal) ||
                    ((state_q == ST_MEM) && mem_done_i);

endmodule

//--- source/execute_unit.sv
// ALU, branch decision and next pc, purely combinational
// SLT compares signed, branch targets are pc relative with no alignment check

`timescale 1ns/1ps

module execute_unit
  import core_pkg::*;
(
  issue_if.execute issue,
  output word_t    alu_result_o,
  output word_t    pc_next_o,
  output logic     pc_load_o
);

  logic equal;
  logic taken;

  always_comb begin
    unique case (issue.alu_op)
      ALU_SUB:    alu_result_o = issue.operand_a - issue.operand_b;
      ALU_AND:    alu_result_o = issue.operand_a & issue.operand_b;
      ALU_OR:     alu_result_o = issue.operand_a | issue.operand_b;
      ALU_XOR:    alu_result_o = issue.operand_a ^ issue.operand_b;
      ALU_SLT: begin
        alu_result_o = word_t'($signed(issue.operand_a) < $signed(issue.operand_b));
      end
      ALU_PASS_B: alu_result_o = issue.operand_b;
      default:    alu_result_o = issue.operand_a + issue.operand_b;
    endcase
  end

  // BEQ and BNE share one comparator
  assign equal = (issue.operand_a == issue.operand_b);
  assign taken = issue.branch_en && (issue.branch_ne ? !equal : equal);

  assign pc_next_o = (taken || issue.jump) ? issue.pc + issue.branch_off
                                           : issue.pc + word_t'(4);

  // The retire strobe loads the pc, in EXEC or on mem_done
  assign pc_load_o = issue.we;

endmodule

//--- source/load_store_unit.sv
// Data port sequencing for LW, LBU, SW and SB
// The address is word aligned on the port, byte lanes come from data_be_o
// Word accesses assume a word aligned effective address

`timescale 1ns/1ps

module load_store_unit
  import core_pkg::*;
(
  input  logic     clk,
  input  logic     rst_ni,
  issue_if.memory  issue,
  input  word_t    alu_result_i,
  output logic     data_req_o,
  input  logic     data_gnt_i,
  input  logic     data_rvalid_i,
  output logic     data_we_o,
  output byte_en_t data_be_o,
  output word_t    data_addr_o,
  output word_t    data_wdata_o,
  input  word_t    data_rdata_i,
  output word_t    load_data_o,
  output logic     mem_done_o
);

  logic       req_q;
  logic       wait_q;
  logic [1:0] offset;
  logic [7:0] load_byte;

  assign offset = alu_result_i[1:0];

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q  <= 1'b0;
      wait_q <= 1'b0;
    end else begin
      if (issue.mem_req) begin
        req_q <= 1'b1;
      end else if (data_gnt_i) begin
        req_q <= 1'b0;
      end
      if (req_q && data_gnt_i) begin
        wait_q <= 1'b1;
      end else if (data_rvalid_i) begin
        wait_q <= 1'b0;
      end
    end
  end

  assign data_req_o  = req_q;
  assign data_we_o   = issue.mem_we;
  assign data_addr_o = {alu_result_i[XLEN-1:2], 2'b00};
  assign mem_done_o  = wait_q & data_rvalid_i;

  // One-hot lane for bytes, store byte copied to every lane
  assign data_be_o    = issue.mem_byte ? byte_en_t'(4'b0001 << offset) : 4'b1111;
  assign data_wdata_o = issue.mem_byte ? {4{issue.store_data[7:0]}} : issue.store_data;

  // LBU zero-extends the addressed lane
  assign load_byte   = data_rdata_i[{offset, 3'b000} +: 8];
  assign load_data_o = issue.mem_byte ? {{(XLEN-8){1'b0}}, load_byte} : data_rdata_i;

endmodule

//--- source/register_file.sv
// 32 x 32 register file with two combinational read ports
// x0 reads as zero and ignores writes, write data is picked by wb_sel

`timescale 1ns/1ps

module register_file
  import core_pkg::*;
(
  input  logic     clk,
  input  logic     rst_ni,
  issue_if.result  issue,
  rf_read_if.file  rf_rd,
  input  word_t    alu_result_i,
  input  word_t    load_data_i
);

  word_t regs_q [1:NUM_REGS-1];
  word_t wdata;

  // Write-back source
  always_comb begin
    unique case (issue.wb_sel)
      WB_LOAD: wdata = load_data_i;
      WB_LINK: wdata = issue.pc + word_t'(4);
      default: wdata = alu_result_i;
    endcase
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (issue.we && issue.rd != '0) begin
      regs_q[issue.rd] <= wdata;
    end
  end

  assign rf_rd.rdata_a = (rf_rd.rs1 == '0) ? '0 : regs_q[rf_rd.rs1];
  assign rf_rd.rdata_b = (rf_rd.rs2 == '0) ? '0 : regs_q[rf_rd.rs2];

endmodule

//--- source/core_top.sv
// Top level of the multi-cycle RV32I subset core
// Fetch starts right after reset, halted_o stays high once an unknown opcode is seen
// Both memory ports use request/grant/rvalid with one transfer outstanding

`timescale 1ns/1ps

module core_top
  import core_pkg::*;
(
  input  logic     clk,
  input  logic     rst_ni,
  input  word_t    boot_addr_i,

  // Instruction port
  output logic     instr_req_o,
  input  logic     instr_gnt_i,
  input  logic     instr_rvalid_i,
  output word_t    instr_addr_o,
  input  word_t    instr_rdata_i,

  // Data port
  output logic     data_req_o,
  input  logic     data_gnt_i,
  input  logic     data_rvalid_i,
  output logic     data_we_o,
  output byte_en_t data_be_o,
  output word_t    data_addr_o,
  output word_t    data_wdata_o,
  input  word_t    data_rdata_i,

  output logic     halted_o
);

  word_t alu_result;
  word_t pc_next;
  logic  pc_load;
  word_t load_data;
  logic  mem_done;
  word_t instr;
  word_t pc;
  logic  instr_done;
  logic  fetch_start;

  issue_if   issue ();
  rf_read_if rf_rd ();

  ////////////////////////////////////////////////////////////////////////////
  // Fetch and decode
  ////////////////////////////////////////////////////////////////////////////

  fetch_unit u_fetch (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .boot_addr_i    (boot_addr_i),
    .fetch_start_i  (fetch_start),
    .pc_next_i      (pc_next),
    .pc_load_i      (pc_load),
    .instr_req_o    (instr_req_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_addr_o   (instr_addr_o),
    .instr_rdata_i  (instr_rdata_i),
    .pc_o           (pc),
    .instr_o        (instr),
    .instr_done_o   (instr_done)
  );

  decode_unit u_decode (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .instr_i       (instr),
    .pc_i          (pc),
    .instr_done_i  (instr_done),
    .mem_done_i    (mem_done),
    .fetch_start_o (fetch_start),
    .halted_o      (halted_o),
    .issue         (issue.decode),
    .rf_rd         (rf_rd.request)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Execute, memory and write-back
  ////////////////////////////////////////////////////////////////////////////

  execute_unit u_execute (
    .issue        (issue.execute),
    .alu_result_o (alu_result),
    .pc_next_o    (pc_next),
    .pc_load_o    (pc_load)
  );

  load_store_unit u_lsu (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .issue         (issue.memory),
    .alu_result_i  (alu_result),
    .data_req_o    (data_req_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_we_o     (data_we_o),
    .data_be_o     (data_be_o),
    .data_addr_o   (data_addr_o),
    .data_wdata_o  (data_wdata_o),
    .data_rdata_i  (data_rdata_i),
    .load_data_o   (load_data),
    .mem_done_o    (mem_done)
  );

  register_file u_rf (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .issue        (issue.result),
    .rf_rd        (rf_rd.file),
    .alu_result_i (alu_result),
    .load_data_i  (load_data)
  );

endmodule

//--- verif/tb_mem_model.sv
// Instruction ROM and data RAM, 64 words each, indexed by address bits [7:2]
// Grant and rvalid delays are 0 to 3 cycles, outputs change 1 ns after the clock edge
// One transfer per port at a time, contents are loaded by the testbench

`timescale 1ns/1ps

module tb_mem_model #(
  parameter int SEED = 1
) (
  input  logic        clk,
  input  logic        rst_ni,
  input  logic        instr_req_i,
  output logic        instr_gnt_o,
  output logic        instr_rvalid_o,
  input  logic [31:0] instr_addr_i,
  output logic [31:0] instr_rdata_o,
  input  logic        data_req_i,
  output logic        data_gnt_o,
  output logic        data_rvalid_o,
  input  logic        data_we_i,
  input  logic [3:0]  data_be_i,
  input  logic [31:0] data_addr_i,
  input  logic [31:0] data_wdata_i,
  output logic [31:0] data_rdata_o
);

  logic [31:0] rom [0:63];
  logic [31:0] ram [0:63];
  integer      seed = SEED;

  function automatic int draw_delay();
    return int'($unsigned($random(seed)) % 4);
  endfunction

  // Wait a number of cycles, ending 1 ns after an edge
  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    instr_gnt_o    = 1'b0;
    instr_rvalid_o = 1'b0;
    instr_rdata_o  = '0;
    forever begin
      idle_cycles(1);
      if (rst_ni && instr_req_i) begin
        idle_cycles(draw_delay());
        instr_gnt_o   = 1'b1;
        instr_rdata_o = rom[instr_addr_i[7:2]];
        idle_cycles(1);
        instr_gnt_o = 1'b0;
        idle_cycles(draw_delay());
        instr_rvalid_o = 1'b1;
        idle_cycles(1);
        instr_rvalid_o = 1'b0;
      end
    end
  end

  initial begin
    data_gnt_o    = 1'b0;
    data_rvalid_o = 1'b0;
    data_rdata_o  = '0;
    forever begin
      idle_cycles(1);
      if (rst_ni && data_req_i) begin
        idle_cycles(draw_delay());
        data_gnt_o   = 1'b1;
        data_rdata_o = ram[data_addr_i[7:2]];
        // Byte lanes written at grant time
        if (data_we_i) begin
          for (int l = 0; l < 4; l++) begin
            if (data_be_i[l]) begin
              ram[data_addr_i[7:2]][8*l +: 8] = data_wdata_i[8*l +: 8];
            end
          end
        end
        idle_cycles(1);
        data_gnt_o = 1'b0;
        idle_cycles(draw_delay());
        data_rvalid_o = 1'b1;
        idle_cycles(1);
        data_rvalid_o = 1'b0;
      end
    end
  end

endmodule

//--- verif/tb_core.sv
// Runs a hand-assembled program on the core and checks every store on the data port
// Program at 0x0, data words A and B at 0x1000 and 0x1004, results from 0x1040 up
// The run ends when the core halts on the final all-zero word

`timescale 1ns/1ps

module tb_core
  import core_pkg::*;
();

  localparam int MAX_CYCLES = 2000;
  localparam int MAX_STORES = 32;
  localparam int SEED       = 32'h75a2;

  logic     clk;
  logic     rst_ni;
  word_t    boot_addr;
  logic     instr_req;
  logic     instr_gnt;
  logic     instr_rvalid;
  word_t    instr_addr;
  word_t    instr_rdata;
  logic     data_req;
  logic     data_gnt;
  logic     data_rvalid;
  logic     data_we;
  byte_en_t data_be;
  word_t    data_addr;
  word_t    data_wdata;
  word_t    data_rdata;
  logic     halted;

  integer   seed = SEED;
  word_t    val_a;
  word_t    val_b;
  int       pc_idx;
  int       cycles;
  int       n_exp;
  int       st_idx;
  word_t    jal_pc;
  string    exp_name [MAX_STORES];
  word_t    exp_addr [MAX_STORES];
  byte_en_t exp_be   [MAX_STORES];
  word_t    exp_data [MAX_STORES];

  core_top dut (
    .clk (clk), .rst_ni (rst_ni), .boot_addr_i (boot_addr),
    .instr_req_o (instr_req), .instr_gnt_i (instr_gnt), .instr_rvalid_i (instr_rvalid),
    .instr_addr_o (instr_addr), .instr_rdata_i (instr_rdata),
    .data_req_o (data_req), .data_gnt_i (data_gnt), .data_rvalid_i (data_rvalid),
    .data_we_o (data_we), .data_be_o (data_be), .data_addr_o (data_addr),
    .data_wdata_o (data_wdata), .data_rdata_i (data_rdata), .halted_o (halted)
  );

  tb_mem_model #(.SEED (SEED)) mem (
    .clk (clk), .rst_ni (rst_ni),
    .instr_req_i (instr_req), .instr_gnt_o (instr_gnt), .instr_rvalid_o (instr_rvalid),
    .instr_addr_i (instr_addr), .instr_rdata_o (instr_rdata),
    .data_req_i (data_req), .data_gnt_o (data_gnt), .data_rvalid_o (data_rvalid),
    .data_we_i (data_we), .data_be_i (data_be), .data_addr_i (data_addr),
    .data_wdata_i (data_wdata), .data_rdata_o (data_rdata)
  );

  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction encoders and expected stores
  ////////////////////////////////////////////////////////////////////////////

  function automatic word_t enc_r(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
  endfunction

  function automatic word_t enc_i(logic [11:0] imm, int rs1, logic [2:0] f3, int rd,
                                  logic [6:0] op);
    return {imm, 5'(rs1), f3, 5'(rd), op};
  endfunction

  function automatic word_t enc_s(logic [11:0] imm, int rs2, int rs1, logic [2:0] f3);
    return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t enc_b(logic [12:0] imm, int rs2, int rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  task automatic emit(input word_t w);
    mem.rom[pc_idx] = w;
    pc_idx++;
  endtask

  task automatic expect_store(input string name, input word_t addr, input byte_en_t be,
                              input word_t data);
    exp_name[n_exp] = name;
    exp_addr[n_exp] = addr;
    exp_be[n_exp]   = be;
    exp_data[n_exp] = data;
    n_exp++;
  endtask

  task automatic report_mismatch(input string name, input string field, input word_t exp,
                                 input word_t act);
    $display("[ERROR] %s %s: expected %h, actual %h", name, field, exp, act);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (data_req && data_gnt && data_we) begin
      st_idx <= st_idx + 1;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_ni)
    (data_req && data_gnt && data_we) |-> st_idx < n_exp)
    else abort_run("The core wrote more stores than the program should produce");
  assert property (@(posedge clk) disable iff (!rst_ni)
    (data_req && data_gnt && data_we) |-> data_addr == exp_addr[st_idx])
    else report_mismatch(exp_name[$sampled(st_idx)], "address",
                         exp_addr[$sampled(st_idx)], $sampled(data_addr));
  assert property (@(posedge clk) disable iff (!rst_ni)
    (data_req && data_gnt && data_we) |-> data_be == exp_be[st_idx])
    else report_mismatch(exp_name[$sampled(st_idx)], "byte enables",
                         word_t'(exp_be[$sampled(st_idx)]), word_t'($sampled(data_be)));
  assert property (@(posedge clk) disable iff (!rst_ni)
    (data_req && data_gnt && data_we) |-> data_wdata == exp_data[st_idx])
    else report_mismatch(exp_name[$sampled(st_idx)], "write data",
                         exp_data[$sampled(st_idx)], $sampled(data_wdata));

  // Requests hold until granted
  assert property (@(posedge clk) disable iff (!rst_ni)
    (data_req && !data_gnt) |=> data_req && $stable(data_addr) && $stable(data_we) &&
                                $stable(data_be) && $stable(data_wdata))
    else abort_run("A data request changed or dropped before its grant");
  assert property (@(posedge clk) disable iff (!rst_ni)
    (instr_req && !instr_gnt) |=> instr_req && $stable(instr_addr))
    else abort_run("An instruction request changed or dropped before its grant");
  assert property (@(posedge clk) disable iff (!rst_ni)
    halted |-> !instr_req && !data_req)
    else abort_run("The core raised a request while halted");
  assert property (@(posedge clk) disable iff (!rst_ni) halted |=> halted)
    else abort_run("halted_o dropped after the core halted");

  always @(posedge clk) begin
    cycles <= cycles + 1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Program and run
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk       = 1'b0;
    rst_ni    = 1'b0;
    boot_addr = '0;
    cycles    = 0;
    n_exp     = 0;
    st_idx    = 0;
    pc_idx    = 0;
    val_a     = $random(seed);
    val_b     = $random(seed);
    if (val_b == val_a) begin
      val_b = ~val_a;
    end
    #1;
    mem.ram[0] = val_a;
    mem.ram[1] = val_b;

    // x1 = 0x1000, x2 = A, x3 = B
    emit({20'h00001, 5'd1, 7'b0110111});
    emit(enc_i(12'd0, 1, 3'b010, 2, 7'b0000011));
    emit(enc_i(12'd4, 1, 3'b010, 3, 7'b0000011));
    // Register arithmetic
    emit(enc_r(7'h00, 3, 2, 3'b000, 4));
    emit(enc_s(12'h040, 4, 1, 3'b010));
    expect_store("add", 32'h1040, 4'hf, val_a + val_b);
    emit(enc_r(7'h20, 3, 2, 3'b000, 4));
    emit(enc_s(12'h044, 4, 1, 3'b010));
    expect_store("sub", 32'h1044, 4'hf, val_a - val_b);
    emit(enc_r(7'h00, 3, 2, 3'b111, 4));
    emit(enc_s(12'h048, 4, 1, 3'b010));
    expect_store("and", 32'h1048, 4'hf, val_a & val_b);
    emit(enc_r(7'h00, 3, 2, 3'b110, 4));
    emit(enc_s(12'h04c, 4, 1, 3'b010));
    expect_store("or", 32'h104c, 4'hf, val_a | val_b);
    emit(enc_r(7'h00, 3, 2, 3'b100, 4));
    emit(enc_s(12'h050, 4, 1, 3'b010));
    expect_store("xor", 32'h1050, 4'hf, val_a ^ val_b);
    emit(enc_r(7'h00, 3, 2, 3'b010, 4));
    emit(enc_s(12'h054, 4, 1, 3'b010));
    expect_store("slt", 32'h1054, 4'hf, word_t'($signed(val_a) < $signed(val_b)));
    // Immediates sign-extended from bit 11
    emit(enc_i(12'hffb, 2, 3'b000, 4, 7'b0010011));
    emit(enc_s(12'h058, 4, 1, 3'b010));
    expect_store("addi", 32'h1058, 4'hf, val_a + 32'hffff_fffb);
    emit(enc_i(12'h0f0, 2, 3'b111, 4, 7'b0010011));
    emit(enc_s(12'h05c, 4, 1, 3'b010));
    expect_store("andi", 32'h105c, 4'hf, val_a & 32'h0000_00f0);
    emit(enc_i(12'hf00, 2, 3'b110, 4, 7'b0010011));
    emit(enc_s(12'h060, 4, 1, 3'b010));
    expect_store("ori", 32'h1060, 4'hf, val_a | 32'hffff_ff00);
    emit(enc_i(12'h555, 2, 3'b100, 4, 7'b0010011));
    emit(enc_s(12'h064, 4, 1, 3'b010));
    expect_store("xori", 32'h1064, 4'hf, val_a ^ 32'h0000_0555);
    emit(enc_i(12'hfff, 2, 3'b010, 4, 7'b0010011));
    emit(enc_s(12'h068, 4, 1, 3'b010));
    expect_store("slti", 32'h1068, 4'hf, word_t'($signed(val_a) < -1));
    emit({20'habcde, 5'd4, 7'b0110111});
    emit(enc_s(12'h06c, 4, 1, 3'b010));
    expect_store("lui", 32'h106c, 4'hf, 32'habcd_e000);
    emit(enc_i(12'h007, 2, 3'b000, 0, 7'b0010011));
    emit(enc_s(12'h070, 0, 1, 3'b010));
    expect_store("x0 write", 32'h1070, 4'hf, 32'h0);
    // Byte stores to every lane, then LBU of byte 2 of A
    emit(enc_s(12'h074, 2, 1, 3'b000));
    emit(enc_s(12'h075, 2, 1, 3'b000));
    emit(enc_s(12'h076, 3, 1, 3'b000));
    emit(enc_s(12'h077, 3, 1, 3'b000));
    expect_store("sb lane 0", 32'h1074, 4'b0001, {4{val_a[7:0]}});
    expect_store("sb lane 1", 32'h1074, 4'b0010, {4{val_a[7:0]}});
    expect_store("sb lane 2", 32'h1074, 4'b0100, {4{val_b[7:0]}});
    expect_store("sb lane 3", 32'h1074, 4'b1000, {4{val_b[7:0]}});
    emit(enc_i(12'd2, 1, 3'b100, 5, 7'b0000011));
    emit(enc_s(12'h078, 5, 1, 3'b010));
    expect_store("lbu", 32'h1078, 4'hf, {24'h0, val_a[23:16]});
    // Wrong-path stores in the branches below would break the store order
    emit(enc_i(12'd1, 0, 3'b000, 6, 7'b0010011));
    emit(enc_b(13'd8, 2, 2, 3'b000));
    emit(enc_s(12'h07c, 6, 1, 3'b010));
    emit(enc_b(13'd8, 3, 2, 3'b000));
    emit(enc_s(12'h07c, 6, 1, 3'b010));
    expect_store("beq", 32'h107c, 4'hf, 32'h1);
    emit(enc_b(13'd8, 3, 2, 3'b001));
    emit(enc_s(12'h080, 0, 1, 3'b010));
    emit(enc_b(13'd8, 2, 2, 3'b001));
    emit(enc_s(12'h080, 6, 1, 3'b010));
    expect_store("bne", 32'h1080, 4'hf, 32'h1);
    jal_pc = word_t'(4 * pc_idx);
    emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd7, 7'b1101111});
    emit(enc_s(12'h084, 6, 1, 3'b010));
    emit(enc_s(12'h084, 7, 1, 3'b010));
    expect_store("jal link", 32'h1084, 4'hf, jal_pc + 32'd4);
    // Unknown opcode ends the program
    emit(32'h0000_0000);

    repeat (4) @(posedge clk);
    #1 rst_ni = 1'b1;
    while (!halted && cycles < MAX_CYCLES) begin
      @(posedge clk);
    end
    // A few more cycles to watch the halt
    repeat (5) @(posedge clk);
    if (!halted) begin
      abort_run("Timeout, the core did not halt within the cycle limit");
    end else if (st_idx != n_exp) begin
      report_mismatch("store count", "stores", word_t'(n_exp), word_t'(st_idx));
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

//--- project.f
source/core_pkg.sv
source/core_ifs.sv
source/fetch_unit.sv
source/decode_unit.sv
source/execute_unit.sv
source/load_store_unit.sv
source/register_file.sv
source/core_top.sv
verif/tb_mem_model.sv
verif/tb_core.sv
